// ==== hawk_bus_pkg.sv ====
package hawk_bus_pkg;

   //////////////////////////////////////////////////////////////////////
   // memory bus widths
   //////////////////////////////////////////////////////////////////////

   // line address, one unit per line
   localparam int ADDR_W = 16;

   // one cache line per beat
   localparam int DATA_W = 64;

   typedef logic [ADDR_W-1:0] mem_addr_t;
   typedef logic [DATA_W-1:0] mem_data_t;

   //////////////////////////////////////////////////////////////////////
   // arbiter source tags
   //////////////////////////////////////////////////////////////////////

   // owner of a read in flight
   typedef enum logic {
      src_cpu  = 1'b0,
      src_hawk = 1'b1
   } src_t;

endpackage

// ==== hawk_ctrl_pkg.sv ====
package hawk_ctrl_pkg;

   //////////////////////////////////////////////////////////////////////
   // page attributes and scan results
   //////////////////////////////////////////////////////////////////////

   // page index width
   localparam int PAGE_W = 8;

   typedef logic [PAGE_W-1:0] page_t;

   // handed from the scanner to the control unit
   typedef struct packed {
      page_t page;
      logic  zero;
   } scan_result_t;

endpackage

// ==== hawk_mem_if.sv ====
`timescale 1ns/1ps

interface hawk_mem_if;
   import hawk_bus_pkg::*;

   // request, master side
   logic      req_valid;
   logic      req_we;
   mem_addr_t req_addr;
   mem_data_t req_wdata;

   // request accept, slave side
   logic      req_ready;

   // read data, in request order
   logic      rsp_valid;
   mem_data_t rsp_rdata;

   modport mstr (
      output req_valid, req_we, req_addr, req_wdata,
      input  req_ready, rsp_valid, rsp_rdata
   );

   modport slv (
      input  req_valid, req_we, req_addr, req_wdata,
      output req_ready, rsp_valid, rsp_rdata
   );

endinterface

// ==== hawk_att_if.sv ====
`timescale 1ns/1ps

interface hawk_att_if;
   import hawk_ctrl_pkg::*;

   // zero-page lookup
   page_t lkup_page;
   logic  lkup_zero;

   // clear strobe on a write to a zero page
   logic  clr_valid;
   page_t clr_page;

   // page under scan
   logic  blk_valid;
   page_t blk_page;

   modport gate (
      output lkup_page, clr_valid, clr_page,
      input  lkup_zero, blk_valid, blk_page
   );

   modport ctrl (
      input  lkup_page, clr_valid, clr_page,
      output lkup_zero, blk_valid, blk_page
   );

endinterface

// ==== hawk_cpu_stall.sv ====
`timescale 1ns/1ps

module hawk_cpu_stall #(
   parameter int PAGE_LINES = 8,
   parameter int ARB_DEPTH  = 4
) (
   input  logic                    clk_i,
   input  logic                    rst_n,
   input  logic                    cpu_req_valid,
   input  logic                    cpu_req_we,
   input  hawk_bus_pkg::mem_addr_t cpu_req_addr,
   input  hawk_bus_pkg::mem_data_t cpu_req_wdata,
   output logic                    cpu_req_ready,
   output logic                    cpu_rsp_valid,
   output hawk_bus_pkg::mem_data_t cpu_rsp_rdata,
   hawk_att_if.gate                att,
   hawk_mem_if.mstr                mem
);
   import hawk_bus_pkg::*;
   import hawk_ctrl_pkg::*;

   localparam int LINE_W = $clog2(PAGE_LINES);
   localparam int FULL_W = ADDR_W - LINE_W;
   // in flight plus the one held here
   localparam int CNT_W  = $clog2(ARB_DEPTH + 2);

   logic [FULL_W-1:0] req_page;
   logic              page_fits;
   logic              is_blk;
   logic              is_zero;
   logic              slot_free;
   logic              take_fwd;
   logic              take_lcl;
   logic              rd_inc;
   logic [CNT_W-1:0]  rd_cnt;
   logic              lcl_valid;
   logic              fwd_valid;
   logic              fwd_we;
   mem_addr_t         fwd_addr;
   mem_data_t         fwd_wdata;

   //////////////////////////////////////////////////////////////////////
   // page attribute check
   //////////////////////////////////////////////////////////////////////

   assign req_page      = cpu_req_addr[ADDR_W-1:LINE_W];
   // pages beyond page_t never match the table
   assign page_fits     = (req_page >> PAGE_W) == '0;
   assign att.lkup_page = page_t'(req_page);

   assign is_blk  = page_fits && att.blk_valid && (att.blk_page == att.lkup_page);
   assign is_zero = page_fits && att.lkup_zero;

   // zero-page read, answered here once memory has no cpu read left
   assign take_lcl  = cpu_req_valid && !is_blk && is_zero && !cpu_req_we && (rd_cnt == '0);
   assign slot_free = !fwd_valid || mem.req_ready;
   assign take_fwd  = cpu_req_valid && !is_blk && !(is_zero && !cpu_req_we) && slot_free;

   assign cpu_req_ready = take_lcl || take_fwd;
   assign rd_inc        = take_fwd && !cpu_req_we;

   // write to a zero page drops the mark
   assign att.clr_valid = take_fwd && cpu_req_we && is_zero;
   assign att.clr_page  = att.lkup_page;

   //////////////////////////////////////////////////////////////////////
   // forward slot and read tracking
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         fwd_valid <= 1'b0;
         lcl_valid <= 1'b0;
         rd_cnt    <= '0;
      end else begin
         lcl_valid <= take_lcl;
         if (take_fwd)
            fwd_valid <= 1'b1;
         else if (mem.req_ready)
            fwd_valid <= 1'b0;
         if (rd_inc && !mem.rsp_valid)
            rd_cnt <= rd_cnt + 1'b1;
         else if (!rd_inc && mem.rsp_valid)
            rd_cnt <= rd_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (take_fwd) begin
         fwd_we    <= cpu_req_we;
         fwd_addr  <= cpu_req_addr;
         fwd_wdata <= cpu_req_wdata;
      end
   end

   assign mem.req_valid = fwd_valid;
   assign mem.req_we    = fwd_we;
   assign mem.req_addr  = fwd_addr;
   assign mem.req_wdata = fwd_wdata;

   assign cpu_rsp_valid = lcl_valid || mem.rsp_valid;
   assign cpu_rsp_rdata = lcl_valid ? '0 : mem.rsp_rdata;

   // local zero data never collides with data from memory
   a_rsp_excl: assert property (@(posedge clk_i) disable iff (!rst_n)
      !(lcl_valid && mem.rsp_valid));

endmodule

// ==== hawk_zspg_scan.sv ====
`timescale 1ns/1ps

module hawk_zspg_scan #(
   parameter int PAGE_LINES = 8
) (
   input  logic                        clk_i,
   input  logic                        rst_n,
   input  logic                        start,
   input  hawk_ctrl_pkg::page_t        start_page,
   output logic                        done,
   output hawk_ctrl_pkg::scan_result_t result,
   hawk_mem_if.mstr                    mem
);
   import hawk_bus_pkg::*;
   import hawk_ctrl_pkg::*;

   localparam int LINE_W = $clog2(PAGE_LINES);

   logic              busy;
   page_t             page_q;
   logic [LINE_W:0]   iss_cnt;
   logic [LINE_W-1:0] rcv_cnt;
   logic              rcv_last;
   mem_data_t         acc;

   //////////////////////////////////////////////////////////////////////
   // read issue, one line per transfer
   //////////////////////////////////////////////////////////////////////

   // msb of iss_cnt set once every line went out
   assign mem.req_valid = busy && !iss_cnt[LINE_W];
   assign mem.req_we    = 1'b0;
   assign mem.req_addr  = mem_addr_t'({page_q, iss_cnt[LINE_W-1:0]});
   assign mem.req_wdata = '0;

   assign rcv_last = (rcv_cnt == {LINE_W{1'b1}});

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         done    <= 1'b0;
         iss_cnt <= '0;
         rcv_cnt <= '0;
      end else begin
         done <= 1'b0;
         if (start && !busy) begin
            busy    <= 1'b1;
            iss_cnt <= '0;
            rcv_cnt <= '0;
         end else if (busy) begin
            if (mem.req_valid && mem.req_ready)
               iss_cnt <= iss_cnt + 1'b1;
            if (mem.rsp_valid) begin
               rcv_cnt <= rcv_cnt + 1'b1;
               if (rcv_last) begin
                  busy <= 1'b0;
                  done <= 1'b1;
               end
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // line accumulator
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (start && !busy) begin
         page_q <= start_page;
         acc    <= '0;
      end else if (busy && mem.rsp_valid) begin
         acc <= acc | mem.rsp_rdata;
         if (rcv_last) begin
            result.page <= page_q;
            result.zero <= ((acc | mem.rsp_rdata) == '0);
         end
      end
   end

endmodule

// ==== hawk_ctrl_unit.sv ====
`timescale 1ns/1ps

module hawk_ctrl_unit #(
   parameter int NUM_PAGES = 16
) (
   input  logic                        clk_i,
   input  logic                        rst_n,
   input  logic                        cmd_valid,
   input  hawk_ctrl_pkg::page_t        cmd_page,
   output logic                        cmd_busy,
   output logic                        cmd_done,
   output logic                        cmd_zero,
   output logic                        scan_start,
   output hawk_ctrl_pkg::page_t        scan_page,
   input  logic                        scan_done,
   input  hawk_ctrl_pkg::scan_result_t scan_result,
   hawk_att_if.ctrl                    att
);
   import hawk_ctrl_pkg::*;

   localparam int IDX_W = $clog2(NUM_PAGES);

   logic [NUM_PAGES-1:0] zero_tbl;
   logic                 cmd_take;

   function automatic logic in_tbl(page_t p);
      return p < NUM_PAGES;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // command sequencing
   //////////////////////////////////////////////////////////////////////

   assign cmd_take = cmd_valid && !cmd_busy;

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         cmd_busy   <= 1'b0;
         cmd_done   <= 1'b0;
         cmd_zero   <= 1'b0;
         scan_start <= 1'b0;
      end else begin
         scan_start <= cmd_take;
         cmd_done   <= 1'b0;
         if (cmd_take) begin
            cmd_busy <= 1'b1;
         end else if (cmd_busy && scan_done) begin
            cmd_busy <= 1'b0;
            cmd_done <= 1'b1;
            cmd_zero <= scan_result.zero;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_take)
         scan_page <= cmd_page;
   end

   // stall cpu traffic to the page under scan
   assign att.blk_valid = cmd_busy && in_tbl(scan_page);
   assign att.blk_page  = scan_page;

   //////////////////////////////////////////////////////////////////////
   // zero-page attribute table
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         zero_tbl <= '0;
      end else begin
         if (att.clr_valid && in_tbl(att.clr_page))
            zero_tbl[att.clr_page[IDX_W-1:0]] <= 1'b0;
         // same page as a clear is impossible, it is blocked
         if (scan_done && in_tbl(scan_result.page))
            zero_tbl[scan_result.page[IDX_W-1:0]] <= scan_result.zero;
      end
   end

   assign att.lkup_zero = in_tbl(att.lkup_page) ? zero_tbl[att.lkup_page[IDX_W-1:0]] : 1'b0;

   // one scan ends per command, never back to back
   a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n)
      cmd_done |=> !cmd_done);

endmodule

// ==== hawk_mem_arb.sv ====
`timescale 1ns/1ps

module hawk_mem_arb #(
   parameter int ARB_DEPTH = 4
) (
   input  logic                    clk_i,
   input  logic                    rst_n,
   hawk_mem_if.slv                 hawk_m,
   hawk_mem_if.slv                 cpu_m,
   output logic                    mem_req_valid,
   output logic                    mem_req_we,
   output hawk_bus_pkg::mem_addr_t mem_req_addr,
   output hawk_bus_pkg::mem_data_t mem_req_wdata,
   input  logic                    mem_req_ready,
   input  logic                    mem_rsp_valid,
   input  hawk_bus_pkg::mem_data_t mem_rsp_rdata
);
   import hawk_bus_pkg::*;

   localparam int PTR_W = $clog2(ARB_DEPTH);
   localparam int CNT_W = $clog2(ARB_DEPTH + 1);

   src_t             cand;
   src_t             lock_src;
   logic             locked;
   logic             pick_hawk;
   logic             push;
   logic             pop;
   logic             tag_full;
   src_t             tag_mem [ARB_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] tag_cnt;

   //////////////////////////////////////////////////////////////////////
   // request select, scanner first
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      if (locked)
         cand = lock_src;
      else if (hawk_m.req_valid)
         cand = src_hawk;
      else
         cand = src_cpu;
   end

   assign pick_hawk = (cand == src_hawk);
   assign tag_full  = (tag_cnt == CNT_W'(ARB_DEPTH));

   // full fifo cannot appear while locked, no push until transfer
   assign mem_req_valid = (pick_hawk ? hawk_m.req_valid : cpu_m.req_valid) && !tag_full;
   assign mem_req_we    = pick_hawk ? hawk_m.req_we    : cpu_m.req_we;
   assign mem_req_addr  = pick_hawk ? hawk_m.req_addr  : cpu_m.req_addr;
   assign mem_req_wdata = pick_hawk ? hawk_m.req_wdata : cpu_m.req_wdata;

   assign hawk_m.req_ready = mem_req_valid && mem_req_ready && pick_hawk;
   assign cpu_m.req_ready  = mem_req_valid && mem_req_ready && !pick_hawk;

   //////////////////////////////////////////////////////////////////////
   // read tag fifo
   //////////////////////////////////////////////////////////////////////

   assign push = mem_req_valid && mem_req_ready && !mem_req_we;
   assign pop  = mem_rsp_valid;

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         locked   <= 1'b0;
         lock_src <= src_cpu;
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         tag_cnt  <= '0;
      end else begin
         // hold the grant until the request goes through
         locked   <= mem_req_valid && !mem_req_ready;
         lock_src <= cand;
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(ARB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(ARB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            tag_cnt <= tag_cnt + 1'b1;
         else if (!push && pop)
            tag_cnt <= tag_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push)
         tag_mem[wr_ptr] <= cand;
   end

   // steer read data by the oldest tag
   assign hawk_m.rsp_valid = mem_rsp_valid && (tag_mem[rd_ptr] == src_hawk);
   assign cpu_m.rsp_valid  = mem_rsp_valid && (tag_mem[rd_ptr] == src_cpu);
   assign hawk_m.rsp_rdata = mem_rsp_rdata;
   assign cpu_m.rsp_rdata  = mem_rsp_rdata;

   // memory answers only reads it was given
   a_no_orphan: assert property (@(posedge clk_i) disable iff (!rst_n)
      mem_rsp_valid |-> (tag_cnt != '0));

endmodule

// ==== hawk_core.sv ====
`timescale 1ns/1ps

module hawk_core #(
   parameter int PAGE_LINES = 8,
   parameter int NUM_PAGES  = 16,
   parameter int ARB_DEPTH  = 4
) (
   input  logic                    clk_i,
   input  logic                    rst_n,

   // cpu side
   input  logic                    cpu_req_valid,
   input  logic                    cpu_req_we,
   input  hawk_bus_pkg::mem_addr_t cpu_req_addr,
   input  hawk_bus_pkg::mem_data_t cpu_req_wdata,
   output logic                    cpu_req_ready,
   output logic                    cpu_rsp_valid,
   output hawk_bus_pkg::mem_data_t cpu_rsp_rdata,

   // memory side
   output logic                    mem_req_valid,
   output logic                    mem_req_we,
   output hawk_bus_pkg::mem_addr_t mem_req_addr,
   output hawk_bus_pkg::mem_data_t mem_req_wdata,
   input  logic                    mem_req_ready,
   input  logic                    mem_rsp_valid,
   input  hawk_bus_pkg::mem_data_t mem_rsp_rdata,

   // scan commands
   input  logic                    cmd_valid,
   input  hawk_ctrl_pkg::page_t    cmd_page,
   output logic                    cmd_busy,
   output logic                    cmd_done,
   output logic                    cmd_zero
);
   import hawk_ctrl_pkg::*;

   logic         scan_start;
   page_t        scan_page;
   logic         scan_done;
   scan_result_t scan_result;

   hawk_att_if att_bus ();
   hawk_mem_if cpu_bus ();
   hawk_mem_if hawk_bus ();

   //////////////////////////////////////////////////////////////////////
   // input side, processing, output side
   //////////////////////////////////////////////////////////////////////

   hawk_cpu_stall #(.PAGE_LINES(PAGE_LINES), .ARB_DEPTH(ARB_DEPTH)) u_cpu_stall (
      .clk_i, .rst_n,
      .cpu_req_valid, .cpu_req_we, .cpu_req_addr, .cpu_req_wdata,
      .cpu_req_ready, .cpu_rsp_valid, .cpu_rsp_rdata,
      .att (att_bus.gate),
      .mem (cpu_bus.mstr)
   );

   hawk_ctrl_unit #(.NUM_PAGES(NUM_PAGES)) u_ctrl_unit (
      .clk_i, .rst_n,
      .cmd_valid, .cmd_page, .cmd_busy, .cmd_done, .cmd_zero,
      .scan_start, .scan_page, .scan_done, .scan_result,
      .att (att_bus.ctrl)
   );

   hawk_zspg_scan #(.PAGE_LINES(PAGE_LINES)) u_zspg_scan (
      .clk_i, .rst_n,
      .start      (scan_start),
      .start_page (scan_page),
      .done       (scan_done),
      .result     (scan_result),
      .mem        (hawk_bus.mstr)
   );

   hawk_mem_arb #(.ARB_DEPTH(ARB_DEPTH)) u_mem_arb (
      .clk_i, .rst_n,
      .hawk_m (hawk_bus.slv),
      .cpu_m  (cpu_bus.slv),
      .mem_req_valid, .mem_req_we, .mem_req_addr, .mem_req_wdata,
      .mem_req_ready, .mem_rsp_valid, .mem_rsp_rdata
   );

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
   input  logic                    clk_i,
   input  logic                    rst_n,
   input  logic                    req_valid,
   input  logic                    req_we,
   input  hawk_bus_pkg::mem_addr_t req_addr,
   input  hawk_bus_pkg::mem_data_t req_wdata,
   output logic                    req_ready,
   output logic                    rsp_valid,
   output hawk_bus_pkg::mem_data_t rsp_rdata
);
   import hawk_bus_pkg::*;

   mem_data_t   mem_arr [2**ADDR_W];
   logic [31:0] rnd;
   logic        pipe_valid;
   mem_data_t   pipe_rdata;
   int          rd_count;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // backdoor load, only while reset is held
   task automatic load_line(input mem_addr_t a, input mem_data_t d);
      mem_arr[a] = d;
   endtask

   always @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         rnd        <= 32'hbd9e;
         req_ready  <= 1'b0;
         pipe_valid <= 1'b0;
         rsp_valid  <= 1'b0;
         rd_count   <= 0;
      end else begin
         // ready roughly three cycles in four
         rnd        <= xorshift(rnd);
         req_ready  <= (rnd[1:0] != 2'b00);
         // read data two cycles after the transfer
         pipe_valid <= req_valid && req_ready && !req_we;
         pipe_rdata <= mem_arr[req_addr];
         rsp_valid  <= pipe_valid;
         rsp_rdata  <= pipe_rdata;
         if (req_valid && req_ready && req_we)
            mem_arr[req_addr] = req_wdata;
         if (req_valid && req_ready && !req_we)
            rd_count <= rd_count + 1;
      end
   end

endmodule

// ==== tb_hawk_core.sv ====
`timescale 1ns/1ps

module tb_hawk_core;
   import hawk_bus_pkg::*;
   import hawk_ctrl_pkg::*;

   localparam int PAGE_LINES = 8;
   // six short tests of at most a few hundred cycles each
   localparam int MAX_CYCLES = 4000;

   logic      clk_i = 1'b0;
   logic      rst_n;
   logic      cpu_req_valid;
   logic      cpu_req_we;
   mem_addr_t cpu_req_addr;
   mem_data_t cpu_req_wdata;
   logic      cpu_req_ready;
   logic      cpu_rsp_valid;
   mem_data_t cpu_rsp_rdata;
   logic      mem_req_valid;
   logic      mem_req_we;
   mem_addr_t mem_req_addr;
   mem_data_t mem_req_wdata;
   logic      mem_req_ready;
   logic      mem_rsp_valid;
   mem_data_t mem_rsp_rdata;
   logic      cmd_valid;
   page_t     cmd_page;
   logic      cmd_busy;
   logic      cmd_done;
   logic      cmd_zero;

   mem_data_t rsp_q [$];
   mem_data_t shadow [mem_addr_t];
   int        cycle_cnt = 0;
   string     test_name = "startup";

   hawk_core dut0 (.*);

   tb_mem_model mem0 (
      .clk_i, .rst_n,
      .req_valid (mem_req_valid),
      .req_we    (mem_req_we),
      .req_addr  (mem_req_addr),
      .req_wdata (mem_req_wdata),
      .req_ready (mem_req_ready),
      .rsp_valid (mem_rsp_valid),
      .rsp_rdata (mem_rsp_rdata)
   );

   always #2 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         $display("TB FAILED");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   // cpu responses in arrival order
   always @(negedge clk_i) begin
      if (rst_n && cpu_rsp_valid)
         rsp_q.push_back(cpu_rsp_rdata);
   end

   //////////////////////////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic check_data(input string name, input mem_data_t exp, input mem_data_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s (%s): expected %h, actual %h", test_name, name, exp, act);
         $display("TB FAILED");
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic check_flag(input string name, input bit exp, input bit act);
      if (act !== exp) begin
         $display("CHECK FAILED %s (%s): expected %0b, actual %0b", test_name, name, exp, act);
         $display("TB FAILED");
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("CHECK FAILED %s (%s): expected %0d, actual %0d", test_name, name, exp, act);
         $display("TB FAILED");
         $fatal(1, "stopping at the first error");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // memory content and addresses
   //////////////////////////////////////////////////////////////////////

   function automatic mem_addr_t line_addr(input page_t p, input int line);
      return mem_addr_t'(int'(p) * PAGE_LINES + line);
   endfunction

   // every address bit shows up and the line is never zero
   function automatic mem_data_t line_pattern(input mem_addr_t a);
      return {~a, a, a ^ 16'h5a5a, a + 16'h1111};
   endfunction

   function automatic mem_data_t expect_line(input mem_addr_t a);
      if (shadow.exists(a))
         return shadow[a];
      return line_pattern(a);
   endfunction

   task automatic preload_line(input mem_addr_t a, input mem_data_t d);
      mem0.load_line(a, d);
      shadow[a] = d;
   endtask

   task automatic zero_page(input page_t p);
      int i;
      for (i = 0; i < PAGE_LINES; i++)
         preload_line(line_addr(p, i), '0);
   endtask

   task automatic preload_memory();
      int a;
      for (a = 0; a < 2**ADDR_W; a++)
         mem0.load_line(mem_addr_t'(a), line_pattern(mem_addr_t'(a)));
      // page 5 zero except one line
      zero_page(8'd5);
      preload_line(line_addr(8'd5, 2), line_pattern(line_addr(8'd5, 2)));
      zero_page(8'd6);
      zero_page(8'd9);
   endtask

   //////////////////////////////////////////////////////////////////////
   // cpu and command port drivers
   //////////////////////////////////////////////////////////////////////

   task automatic drive_req(input logic we, input mem_addr_t a, input mem_data_t d);
      @(posedge clk_i);
      cpu_req_valid <= 1'b1;
      cpu_req_we    <= we;
      cpu_req_addr  <= a;
      cpu_req_wdata <= d;
      @(negedge clk_i);
      while (!cpu_req_ready)
         @(negedge clk_i);
      // transfer happens on this edge
      @(posedge clk_i);
      cpu_req_valid <= 1'b0;
   endtask

   task automatic cpu_write(input mem_addr_t a, input mem_data_t d);
      drive_req(1'b1, a, d);
      shadow[a] = d;
   endtask

   task automatic cpu_read(input mem_addr_t a);
      drive_req(1'b0, a, '0);
   endtask

   task automatic take_rsp(input string name, input mem_data_t exp);
      mem_data_t got;
      while (rsp_q.size() == 0)
         @(negedge clk_i);
      got = rsp_q.pop_front();
      check_data(name, exp, got);
   endtask

   task automatic issue_scan(input page_t p);
      @(posedge clk_i);
      cmd_valid <= 1'b1;
      cmd_page  <= p;
      @(posedge clk_i);
      cmd_valid <= 1'b0;
      @(negedge clk_i);
      check_flag("busy after command", 1'b1, cmd_busy);
   endtask

   task automatic wait_scan(input string name, input bit exp_zero);
      do
         @(negedge clk_i);
      while (!cmd_done);
      check_flag(name, exp_zero, cmd_zero);
      check_flag("busy falls with done", 1'b0, cmd_busy);
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_reset_values();
      test_name = "reset values";
      @(negedge clk_i);
      check_flag("reset cpu_req_ready", 1'b0, cpu_req_ready);
      check_flag("reset cpu_rsp_valid", 1'b0, cpu_rsp_valid);
      check_flag("reset mem_req_valid", 1'b0, mem_req_valid);
      check_flag("reset cmd_busy", 1'b0, cmd_busy);
      check_flag("reset cmd_done", 1'b0, cmd_done);
   endtask

   task automatic test_pass_through();
      int i;
      test_name = "pass-through";
      $display("test: pass-through on page 3");
      for (i = 0; i < 4; i++)
         cpu_write(line_addr(8'd3, i), {16'hd0d0, 16'(i), 32'h600d_f00d});
      for (i = 0; i < 5; i++)
         cpu_read(line_addr(8'd3, i));
      // line 4 still holds its preload
      for (i = 0; i < 5; i++)
         take_rsp("pass-through read", expect_line(line_addr(8'd3, i)));
   endtask

   task automatic test_scan_results();
      int   rd_before;
      src_t tag;
      test_name = "scan results";
      $display("test: scan results");
      tag = src_hawk;
      issue_scan(8'd5);
      wait_scan("scan page 5 with one live line", 1'b0);
      @(negedge clk_i);
      rd_before = mem0.rd_count;
      issue_scan(8'd6);
      wait_scan("scan all-zero page 6", 1'b1);
      check_count("reads per scan", rd_before + PAGE_LINES, mem0.rd_count);
      $display("  page 6 scanned with %0d reads tagged %s", PAGE_LINES, tag.name());
   endtask

   task automatic test_zero_reads();
      int rd_before;
      test_name = "zero-page reads";
      $display("test: reads from a zero page");
      @(negedge clk_i);
      rd_before = mem0.rd_count;
      cpu_read(line_addr(8'd6, 0));
      @(negedge clk_i);
      check_flag("local response one cycle later", 1'b1, cpu_rsp_valid);
      take_rsp("zero page line 0", '0);
      cpu_read(line_addr(8'd6, 5));
      @(negedge clk_i);
      check_flag("local response one cycle later", 1'b1, cpu_rsp_valid);
      take_rsp("zero page line 5", '0);
      check_count("memory reads for zero page", rd_before, mem0.rd_count);
   endtask

   task automatic test_write_zero_page();
      mem_addr_t a;
      int        rd_before;
      test_name = "write to zero page";
      $display("test: write to a zero page");
      a = line_addr(8'd6, 1);
      cpu_write(a, 64'h0bad_cafe_0000_0001);
      @(negedge clk_i);
      rd_before = mem0.rd_count;
      cpu_read(a);
      take_rsp("read after write to zero page", expect_line(a));
      check_count("read reached memory", rd_before + 1, mem0.rd_count);
      issue_scan(8'd6);
      wait_scan("rescan page 6 after write", 1'b0);
   endtask

   task automatic test_stall_during_scan();
      mem_addr_t other;
      mem_addr_t held;
      test_name = "stall during scan";
      $display("test: cpu stall during a scan");
      other = line_addr(8'd3, 0);
      held  = line_addr(8'd9, 3);
      issue_scan(8'd9);
      cpu_read(other);
      @(negedge clk_i);
      check_flag("scan still running", 1'b1, cmd_busy);
      @(posedge clk_i);
      cpu_req_valid <= 1'b1;
      cpu_req_we    <= 1'b0;
      cpu_req_addr  <= held;
      @(negedge clk_i);
      while (!cmd_done) begin
         check_flag("request to page under scan held", 1'b0, cpu_req_ready);
         @(negedge clk_i);
      end
      check_flag("scan page 9", 1'b1, cmd_zero);
      while (!cpu_req_ready)
         @(negedge clk_i);
      @(posedge clk_i);
      cpu_req_valid <= 1'b0;
      take_rsp("other page during scan", expect_line(other));
      take_rsp("held request after scan", '0);
   endtask

   initial begin
      rst_n         = 1'b0;
      cpu_req_valid = 1'b0;
      cpu_req_we    = 1'b0;
      cpu_req_addr  = '0;
      cpu_req_wdata = '0;
      cmd_valid     = 1'b0;
      cmd_page      = '0;
      preload_memory();
      test_reset_values();
      repeat (5) @(posedge clk_i);
      rst_n <= 1'b1;
      test_pass_through();
      test_scan_results();
      test_zero_reads();
      test_write_zero_page();
      test_stall_during_scan();
      test_name = "drain";
      repeat (10) @(negedge clk_i);
      check_count("leftover cpu responses", 0, rsp_q.size());
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== hawk_core.f ====
hawk_bus_pkg.sv
hawk_ctrl_pkg.sv
hawk_mem_if.sv
hawk_att_if.sv
hawk_cpu_stall.sv
hawk_zspg_scan.sv
hawk_ctrl_unit.sv
hawk_mem_arb.sv
hawk_core.sv
tb_mem_model.sv
tb_hawk_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hawk_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f hawk_core.f \
   --top-module tb_hawk_core -o tb_hawk_core > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_hawk_core > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
